// File: rtl/tlcs_mem_pkg.sv
package tlcs_mem_pkg;

    localparam int ADDR_W = 24;  // cpu byte address
    localparam int DATA_W = 32;  // internal data word
    localparam int BUS_W  = 16;  // ram bus

    // source of store data
    typedef enum logic [1:0] {
        SRC_ALU   = 2'd0,
        SRC_PC    = 2'd1,  // zero-extended
        SRC_SR    = 2'd2,  // zero-extended
        SRC_EXCPY = 2'd3   // saved register copy for EX
    } data_src_e;

    // store length, one-hot
    localparam logic [2:0] LEN_BYTE = 3'b001;
    localparam logic [2:0] LEN_WORD = 3'b010;
    localparam logic [2:0] LEN_LONG = 3'b100;

endpackage

// File: rtl/mem_src_sel.sv
`timescale 1ns/1ps

module mem_src_sel (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic                               ldram_en,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    idx_addr,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xsp,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xde,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xhl,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    pc,
    input  logic [15:0]                        op16,
    input  logic [15:0]                        sr,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    imm,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    src_out,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    alu_dout,
    input  logic [1:0]                         regs_we,
    input  logic                               sel_xsp,
    input  logic                               sel_xde,
    input  logic                               sel_xhl,
    input  logic                               sel_op8,
    input  logic                               sel_op16,
    input  logic                               sel_imm,
    input  logic                               rda_imm,
    input  tlcs_mem_pkg::data_src_e            data_sel,
    input  logic                               idx_wr,
    output logic [tlcs_mem_pkg::ADDR_W-1:0]    req_addr,
    output logic [tlcs_mem_pkg::ADDR_W-1:0]    wr_addr,
    output logic [tlcs_mem_pkg::DATA_W-1:0]    wr_data
);
    localparam int AW = tlcs_mem_pkg::ADDR_W;
    localparam int DW = tlcs_mem_pkg::DATA_W;

    logic [15:0] src_cpy;  // source copy for EX

    // read address, operand loads pick their own pointer
    assign req_addr = !ldram_en ? pc :
                      sel_xsp   ? xsp :
                      rda_imm   ? {{(AW-16){1'b0}}, imm[DW-1:16]} :
                      idx_addr;

    assign wr_addr = sel_op8  ? {{(AW-8){1'b0}}, op16[7:0]} :
                     sel_op16 ? {{(AW-16){1'b0}}, op16} :
                     sel_xsp  ? xsp :
                     sel_xde  ? xde :
                     sel_xhl  ? xhl :
                     idx_addr;

    always_comb begin
        unique case (data_sel)
            tlcs_mem_pkg::SRC_ALU: wr_data = alu_dout;
            tlcs_mem_pkg::SRC_PC:  wr_data = {{(DW-AW){1'b0}}, pc};
            tlcs_mem_pkg::SRC_SR:  wr_data = {{(DW-16){1'b0}}, sr};
            default:               wr_data = {{(DW-16){1'b0}}, src_cpy};
        endcase
        if (sel_imm) begin
            wr_data[15:0] = imm[15:0];  // immediate low half
        end
    end

    always_ff @(posedge clk) begin
        if (cen && regs_we != 2'd0) begin
            src_cpy <= src_out[15:0];
        end
    end

    // a store address comes from one pointer at a time
    a_one_wr_sel: assert property (@(posedge clk) disable iff (rst)
        (cen && idx_wr) |-> $onehot0({sel_op8, sel_op16, sel_xsp, sel_xde, sel_xhl}));

endmodule

// File: rtl/mem_read_window.sv
`timescale 1ns/1ps

module mem_read_window (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    req_addr,
    input  logic                               ldram_en,
    input  logic                               wr_busy,
    input  logic [tlcs_mem_pkg::BUS_W-1:0]     ram_dout,
    output logic [tlcs_mem_pkg::ADDR_W-1:0]    rd_addr,
    output logic [tlcs_mem_pkg::DATA_W-1:0]    dout,
    output logic                               ram_rdy
);
    localparam int AW = tlcs_mem_pkg::ADDR_W;
    localparam int DW = tlcs_mem_pkg::DATA_W;

    logic [AW-1:0] base;          // address of window byte 0
    logic [DW-1:0] win;
    logic [3:0]    valid;
    logic [3:0]    pend;          // bytes still to fetch
    logic [AW-1:0] sv_base;       // opcode window kept during a load
    logic [DW-1:0] sv_win;
    logic          sv_ok;
    logic          ld_q;

    logic [AW-1:0] byte_addr [4];
    logic [7:0]    lane_byte [4];
    logic [3:0]    lane_hit;
    logic [AW-1:0] delta;
    logic          ld_rise;
    logic          ld_fall;
    logic          restore;
    logic          fetching;
    logic          miss;
    logic          shift1;
    logic          shift2;
    logic          shift3;

    for (genvar g = 0; g < 4; g++) begin : g_lane
        assign byte_addr[g] = base + AW'(g);
        assign lane_hit[g]  = pend[g] && byte_addr[g][AW-1:1] == rd_addr[AW-1:1];
        assign lane_byte[g] = byte_addr[g][0] ? ram_dout[15:8] : ram_dout[7:0];
    end

    assign delta    = req_addr - base;
    assign ld_rise  = ldram_en && !ld_q;
    assign ld_fall  = !ldram_en && ld_q;
    assign restore  = ld_fall && sv_ok;
    assign fetching = pend != 4'd0;
    assign miss     = (req_addr != base || valid != 4'hf) && !fetching;
    // moves that keep part of the window
    assign shift1   = delta == AW'(1) && &valid[3:1];
    assign shift2   = delta == AW'(2) && &valid[3:2];
    assign shift3   = delta == AW'(3) && valid[3];

    assign ram_rdy = &valid && base == req_addr && !wr_busy;
    assign dout    = win;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base    <= '0;
            rd_addr <= '0;
            valid   <= '0;
            pend    <= '0;
            sv_ok   <= 1'b0;
            ld_q    <= 1'b0;
        end else if (cen) begin
            ld_q <= ldram_en;
            if (wr_busy) begin
                valid <= '0;  // ram changed under the window
                pend  <= '0;
                sv_ok <= 1'b0;
            end else begin
                if (ld_rise) begin
                    sv_ok <= &valid;
                end
                if (restore) begin
                    base  <= sv_base;
                    valid <= 4'hf;
                    pend  <= '0;
                end else if (fetching) begin
                    for (int i = 0; i < 4; i++) begin
                        if (lane_hit[i]) begin
                            valid[i] <= 1'b1;
                            pend[i]  <= 1'b0;
                        end
                    end
                    rd_addr <= rd_addr + AW'(2);  // next word
                end else if (miss) begin
                    base <= req_addr;
                    if (shift1) begin
                        valid   <= 4'b0111;
                        pend    <= 4'b1000;
                        rd_addr <= req_addr + AW'(3);
                    end else if (shift2) begin
                        valid   <= 4'b0011;
                        pend    <= 4'b1100;
                        rd_addr <= req_addr + AW'(2);
                    end else if (shift3) begin
                        valid   <= 4'b0001;
                        pend    <= 4'b1110;
                        rd_addr <= req_addr + AW'(1);
                    end else begin
                        valid   <= 4'b0000;  // full refill
                        pend    <= 4'b1111;
                        rd_addr <= req_addr;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !wr_busy) begin
            if (ld_rise) begin
                sv_base <= base;
                sv_win  <= win;
            end
            if (restore) begin
                win <= sv_win;
            end else if (fetching) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_hit[i]) begin
                        win[8*i +: 8] <= lane_byte[i];
                    end
                end
            end else if (miss) begin
                if (shift1) begin
                    win <= {8'd0, win[DW-1:8]};
                end else if (shift2) begin
                    win <= {16'd0, win[DW-1:16]};
                end else if (shift3) begin
                    win <= {24'd0, win[DW-1:24]};
                end
            end
        end
    end

    // a store beat keeps the window closed for the following cycle too
    a_no_rdy_in_wr: assert property (@(posedge clk) disable iff (rst)
        (cen && wr_busy) |-> !ram_rdy ##1 !ram_rdy);

endmodule

// File: rtl/mem_write_split.sv
`timescale 1ns/1ps

module mem_write_split (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic                               idx_wr,
    input  logic [2:0]                         len,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    wr_addr,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    wr_data,
    output logic [tlcs_mem_pkg::ADDR_W-1:0]    wr_addr_out,
    output logic [tlcs_mem_pkg::BUS_W-1:0]     ram_din,
    output logic [1:0]                         ram_we,
    output logic                               wr_busy,
    output logic                               wr_active
);
    localparam int AW = tlcs_mem_pkg::ADDR_W;
    localparam int DW = tlcs_mem_pkg::DATA_W;

    logic [1:0]    beat;      // beats left after the current one
    logic [AW-1:0] cur_addr;
    logic [DW-1:8] data_q;    // low byte always goes out on the first beat
    logic          odd_q;
    logic          long_q;
    logic          first;
    logic          is_word;
    logic          is_long;

    assign is_word     = len == tlcs_mem_pkg::LEN_WORD;
    assign is_long     = len == tlcs_mem_pkg::LEN_LONG;
    assign first       = idx_wr && beat == 2'd0;
    assign wr_active   = beat != 2'd0;
    assign wr_addr_out = cur_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat     <= '0;
            cur_addr <= '0;
            ram_din  <= '0;
            ram_we   <= '0;
            wr_busy  <= 1'b0;
            odd_q    <= 1'b0;
            long_q   <= 1'b0;
        end else if (cen) begin
            ram_we  <= 2'b00;
            wr_busy <= 1'b0;
            if (first) begin
                cur_addr <= wr_addr;
                odd_q    <= wr_addr[0];
                long_q   <= is_long;
                wr_busy  <= 1'b1;
                if (len == tlcs_mem_pkg::LEN_BYTE) begin
                    ram_din <= {2{wr_data[7:0]}};
                    ram_we  <= {wr_addr[0], ~wr_addr[0]};  // lane by address bit 0
                end else if (wr_addr[0]) begin
                    ram_din <= {2{wr_data[7:0]}};  // low byte on the high lane
                    ram_we  <= 2'b10;
                end else begin
                    ram_din <= wr_data[15:0];
                    ram_we  <= 2'b11;
                end
                if (is_long) begin
                    beat <= wr_addr[0] ? 2'd2 : 2'd1;
                end else begin
                    beat <= (is_word && wr_addr[0]) ? 2'd1 : 2'd0;
                end
            end else if (wr_active) begin
                cur_addr <= cur_addr + AW'(2);
                wr_busy  <= 1'b1;
                beat     <= beat - 2'd1;
                if (!odd_q) begin
                    ram_din <= data_q[31:16];  // even long, upper half
                    ram_we  <= 2'b11;
                end else if (long_q && beat == 2'd2) begin
                    ram_din <= data_q[23:8];
                    ram_we  <= 2'b11;
                end else if (long_q) begin
                    ram_din <= {2{data_q[31:24]}};
                    ram_we  <= 2'b01;
                end else begin
                    ram_din <= {2{data_q[15:8]}};  // odd word tail
                    ram_we  <= 2'b01;
                end
            end
        end
    end

    // store data is held here for the later beats
    always_ff @(posedge clk) begin
        if (cen && first) begin
            data_q <= wr_data[DW-1:8];
        end
    end

    a_len_onehot: assert property (@(posedge clk) disable iff (rst)
        (cen && idx_wr) |-> $onehot(len));

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        (cen && idx_wr) |-> !wr_active);

endmodule

// File: rtl/mem_ram16.sv
`timescale 1ns/1ps

module mem_ram16 #(
    parameter int RAM_AW = 12  // word address width
) (
    input  logic                               clk,
    input  logic                               cen,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    addr,
    input  logic [tlcs_mem_pkg::BUS_W-1:0]     din,
    input  logic [1:0]                         we,
    output logic [tlcs_mem_pkg::BUS_W-1:0]     dout
);
    logic [tlcs_mem_pkg::BUS_W-1:0] mem [2**RAM_AW];
    logic [RAM_AW-1:0]              word_idx;

    assign word_idx = addr[RAM_AW:1];  // byte address to word
    assign dout     = mem[word_idx];   // zero-wait read

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we[0]) begin
                mem[word_idx][7:0] <= din[7:0];
            end
            if (we[1]) begin
                mem[word_idx][15:8] <= din[15:8];
            end
        end
    end

endmodule

// File: rtl/tlcs_memctl.sv
`timescale 1ns/1ps

module tlcs_memctl #(
    parameter int RAM_AW = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic                               ldram_en,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    idx_addr,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xsp,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xde,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    xhl,
    input  logic [tlcs_mem_pkg::ADDR_W-1:0]    pc,
    input  logic [15:0]                        op16,
    input  logic [15:0]                        sr,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    imm,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    src_out,
    input  logic [tlcs_mem_pkg::DATA_W-1:0]    alu_dout,
    input  logic [1:0]                         regs_we,
    input  logic                               sel_xsp,
    input  logic                               sel_xde,
    input  logic                               sel_xhl,
    input  logic                               sel_op8,
    input  logic                               sel_op16,
    input  logic                               sel_imm,
    input  logic                               rda_imm,
    input  tlcs_mem_pkg::data_src_e            data_sel,
    input  logic                               idx_wr,
    input  logic [2:0]                         len,
    output logic [tlcs_mem_pkg::DATA_W-1:0]    dout,
    output logic                               ram_rdy,
    output logic [tlcs_mem_pkg::ADDR_W-1:0]    ram_addr,
    output logic [tlcs_mem_pkg::BUS_W-1:0]     ram_din,
    output logic [1:0]                         ram_we
);
    logic [tlcs_mem_pkg::ADDR_W-1:0] req_addr;
    logic [tlcs_mem_pkg::ADDR_W-1:0] wr_addr;
    logic [tlcs_mem_pkg::DATA_W-1:0] wr_data;
    logic [tlcs_mem_pkg::ADDR_W-1:0] rd_addr;
    logic [tlcs_mem_pkg::ADDR_W-1:0] wr_addr_out;
    logic [tlcs_mem_pkg::BUS_W-1:0]  ram_dout;
    logic                            wr_busy;
    logic                            wr_active;
    logic                            mux_wr;

    // splitter owns the ram address while a store runs
    assign mux_wr   = wr_busy || wr_active;
    assign ram_addr = mux_wr ? wr_addr_out : rd_addr;

    mem_src_sel u_src_sel (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .xde      (xde),
        .xhl      (xhl),
        .pc       (pc),
        .op16     (op16),
        .sr       (sr),
        .imm      (imm),
        .src_out  (src_out),
        .alu_dout (alu_dout),
        .regs_we  (regs_we),
        .sel_xsp  (sel_xsp),
        .sel_xde  (sel_xde),
        .sel_xhl  (sel_xhl),
        .sel_op8  (sel_op8),
        .sel_op16 (sel_op16),
        .sel_imm  (sel_imm),
        .rda_imm  (rda_imm),
        .data_sel (data_sel),
        .idx_wr   (idx_wr),
        .req_addr (req_addr),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    mem_read_window u_window (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .req_addr (req_addr),
        .ldram_en (ldram_en),
        .wr_busy  (wr_busy),
        .ram_dout (ram_dout),
        .rd_addr  (rd_addr),
        .dout     (dout),
        .ram_rdy  (ram_rdy)
    );

    mem_write_split u_wr_split (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .idx_wr      (idx_wr),
        .len         (len),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_addr_out (wr_addr_out),
        .ram_din     (ram_din),
        .ram_we      (ram_we),
        .wr_busy     (wr_busy),
        .wr_active   (wr_active)
    );

    mem_ram16 #(
        .RAM_AW (RAM_AW)
    ) u_ram (
        .clk  (clk),
        .cen  (cen),
        .addr (ram_addr),
        .din  (ram_din),
        .we   (ram_we),
        .dout (ram_dout)
    );

endmodule

// File: tb/tb_tlcs_memctl.sv
`timescale 1ns/1ps

module tb_tlcs_memctl;

    localparam int RAM_AW     = 6;   // 128 bytes, addresses wrap
    localparam int N_FILL     = 32;
    localparam int N_RAND_RD  = 16;
    localparam int N_REP      = 3;
    localparam int N_LD       = 4;
    localparam int N_MIX      = 40;
    localparam int N_OPS      = 2*N_FILL + 5*N_RAND_RD + 4*6*N_REP + 8 + 3*N_LD + 3*N_MIX;
    localparam int TIMEOUT_NS = N_OPS * 10 * 40;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        ldram_en;
    logic [23:0] idx_addr;
    logic [23:0] xsp;
    logic [23:0] xde;
    logic [23:0] xhl;
    logic [23:0] pc;
    logic [15:0] op16;
    logic [15:0] sr;
    logic [31:0] imm;
    logic [31:0] src_out;
    logic [31:0] alu_dout;
    logic [1:0]  regs_we;
    logic        sel_xsp;
    logic        sel_xde;
    logic        sel_xhl;
    logic        sel_op8;
    logic        sel_op16;
    logic        sel_imm;
    logic        rda_imm;
    logic        idx_wr;
    logic [2:0]  len;
    tlcs_mem_pkg::data_src_e data_sel;
    logic [31:0] dout;
    logic        ram_rdy;
    logic [23:0] ram_addr;
    logic [15:0] ram_din;
    logic [1:0]  ram_we;

    logic [7:0]  shadow [128];  // byte image of the RAM
    logic [31:0] lfsr_state = 32'ha367;
    logic [31:0] exp_dout;
    logic        chk_rd;
    logic        chk_restore;
    logic        rand_cen;

    tlcs_memctl #(
        .RAM_AW (RAM_AW)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .xde      (xde),
        .xhl      (xhl),
        .pc       (pc),
        .op16     (op16),
        .sr       (sr),
        .imm      (imm),
        .src_out  (src_out),
        .alu_dout (alu_dout),
        .regs_we  (regs_we),
        .sel_xsp  (sel_xsp),
        .sel_xde  (sel_xde),
        .sel_xhl  (sel_xhl),
        .sel_op8  (sel_op8),
        .sel_op16 (sel_op16),
        .sel_imm  (sel_imm),
        .rda_imm  (rda_imm),
        .data_sel (data_sel),
        .idx_wr   (idx_wr),
        .len      (len),
        .dout     (dout),
        .ram_rdy  (ram_rdy),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_fail(input string name, input logic [31:0] expv, input logic [31:0] actv);
        fail_run($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, expv, actv));
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int byte_count(input logic [2:0] ln);
        if (ln == tlcs_mem_pkg::LEN_LONG) begin
            return 4;
        end
        return (ln == tlcs_mem_pkg::LEN_WORD) ? 2 : 1;
    endfunction

    function automatic logic [2:0] len_code(input int k);
        if (k == 0) begin
            return tlcs_mem_pkg::LEN_BYTE;
        end
        return (k == 1) ? tlcs_mem_pkg::LEN_WORD : tlcs_mem_pkg::LEN_LONG;
    endfunction

    // little endian, byte at addr lowest
    function automatic logic [31:0] window_bytes(input logic [23:0] addr);
        logic [31:0] w;
        logic [6:0]  idx;
        for (int i = 0; i < 4; i++) begin
            idx = addr[6:0] + 7'(i);
            w[8*i +: 8] = shadow[idx];
        end
        return w;
    endfunction

    task automatic shadow_store(input logic [23:0] addr, input logic [2:0] ln,
                                input logic [31:0] data);
        logic [6:0] idx;
        for (int i = 0; i < byte_count(ln); i++) begin
            idx = addr[6:0] + 7'(i);
            shadow[idx] = data[8*i +: 8];
        end
    endtask

    task automatic drive_cen();
        cen = rand_cen ? (rand_bits(2) != 32'd0) : 1'b1;  // 3 of 4 cycles when random
    endtask

    task automatic wait_rdy();
        do begin
            @(negedge clk);
            drive_cen();
        end while (!ram_rdy);
    endtask

    task automatic read_at(input logic [23:0] addr);
        pc       = addr;
        exp_dout = window_bytes(addr);
        chk_rd   = 1'b1;
        wait_rdy();
        @(negedge clk);  // one checked edge with ram_rdy high
        drive_cen();
        chk_rd = 1'b0;
    endtask

    // caller sets the data source inputs first
    task automatic store_req(input logic [23:0] addr, input logic [2:0] ln,
                             input logic [31:0] wdata);
        logic acc;
        idx_addr = addr;
        len      = ln;
        idx_wr   = 1'b1;
        acc      = 1'b0;
        while (!acc) begin
            @(posedge clk);
            acc = cen;
            @(negedge clk);
            drive_cen();
        end
        idx_wr = 1'b0;
        shadow_store(addr, ln, wdata);
    endtask

    task automatic store_alu(input logic [23:0] addr, input logic [2:0] ln,
                             input logic [31:0] d);
        alu_dout = d;
        data_sel = tlcs_mem_pkg::SRC_ALU;
        store_req(addr, ln, d);
    endtask

    task automatic operand_load(input logic [23:0] op_pc, input logic [23:0] sp);
        read_at(op_pc);
        ldram_en = 1'b1;
        sel_xsp  = 1'b1;
        xsp      = sp;
        exp_dout = window_bytes(sp);
        chk_rd   = 1'b1;
        wait_rdy();
        @(negedge clk);
        chk_rd = 1'b0;
        ldram_en    = 1'b0;
        sel_xsp     = 1'b0;
        exp_dout    = window_bytes(op_pc);  // opcode window comes back
        chk_restore = 1'b1;
        @(negedge clk);  // restore edge
        @(negedge clk);  // checked edge
        chk_restore = 1'b0;
    endtask

    a_rst_we: assert property (@(posedge clk) rst |-> ram_we == 2'b00)
        else value_fail("ram_we", 32'd0, 32'($sampled(ram_we)));

    a_rst_rdy: assert property (@(posedge clk) rst |-> !ram_rdy)
        else value_fail("ram_rdy", 32'd0, 32'($sampled(ram_rdy)));

    a_rst_addr: assert property (@(posedge clk) rst |-> ram_addr == '0)
        else value_fail("ram_addr", 32'd0, 32'($sampled(ram_addr)));

    a_rst_din: assert property (@(posedge clk) rst |-> ram_din == '0)
        else value_fail("ram_din", 32'd0, 32'($sampled(ram_din)));

    a_rdy_after_rst: assert property (@(posedge clk) $fell(rst) |-> !ram_rdy)
        else value_fail("ram_rdy", 32'd0, 32'($sampled(ram_rdy)));

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (chk_rd && ram_rdy) |-> dout == exp_dout)
        else value_fail("dout", $sampled(exp_dout), $sampled(dout));

    a_store_no_rdy: assert property (@(posedge clk) disable iff (rst)
        (ram_we != 2'b00) |-> !ram_rdy)
        else value_fail("ram_rdy", 32'd0, 32'($sampled(ram_rdy)));

    a_restore_rdy: assert property (@(posedge clk) disable iff (rst)
        (chk_restore && $fell(ldram_en)) |=> ram_rdy)
        else value_fail("ram_rdy", 32'd1, 32'($sampled(ram_rdy)));

    a_restore_data: assert property (@(posedge clk) disable iff (rst)
        (chk_restore && $fell(ldram_en)) |=> dout == exp_dout)
        else value_fail("dout", $sampled(exp_dout), $sampled(dout));

    initial begin
        #(TIMEOUT_NS);
        fail_run("timeout: the DUT did not finish the tests in time");
    end

    initial begin
        logic [23:0] a;
        logic [31:0] d;
        logic [31:0] c;
        clk = 1'b0;
        rst = 1'b0;
        cen = 1'b1;
        ldram_en = 1'b0;
        idx_addr = '0;
        xsp = '0;
        xde = '0;
        xhl = '0;
        pc = '0;
        op16 = '0;
        sr = '0;
        imm = '0;
        src_out = '0;
        alu_dout = '0;
        regs_we = 2'b00;
        sel_xsp = 1'b0;
        sel_xde = 1'b0;
        sel_xhl = 1'b0;
        sel_op8 = 1'b0;
        sel_op16 = 1'b0;
        sel_imm = 1'b0;
        rda_imm = 1'b0;
        data_sel = tlcs_mem_pkg::SRC_ALU;
        idx_wr = 1'b0;
        len = tlcs_mem_pkg::LEN_BYTE;
        exp_dout = '0;
        chk_rd = 1'b0;
        chk_restore = 1'b0;
        rand_cen = 1'b0;
        #1 rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // fill the whole ram with aligned longs
        for (int i = 0; i < N_FILL; i++) begin
            a = {17'(rand_bits(17)), 7'(i * 4)};
            store_alu(a, tlcs_mem_pkg::LEN_LONG, rand_bits(32));
            read_at(a);
        end

        // random reads, then steps that reuse part of the window
        for (int i = 0; i < N_RAND_RD; i++) begin
            a = 24'(rand_bits(24));
            read_at(a);
            for (int s = 1; s <= 4; s++) begin
                a = a + 24'(s);
                read_at(a);
            end
        end

        // all lengths at both alignments
        for (int r = 0; r < N_REP; r++) begin
            for (int k = 0; k < 3; k++) begin
                for (int odd = 0; odd < 2; odd++) begin
                    a = {23'(rand_bits(23)), 1'(odd)};
                    store_alu(a, len_code(k), rand_bits(32));
                    read_at(a);
                    read_at(a - 24'd1);  // lower neighbour
                    read_at(a + 24'd1);  // upper neighbour of a long
                end
            end
        end

        // write data sources
        a = 24'(rand_bits(24));
        data_sel = tlcs_mem_pkg::SRC_PC;
        store_req(a, tlcs_mem_pkg::LEN_LONG, {8'h00, pc});
        read_at(a);
        a = 24'(rand_bits(24));
        sr = 16'(rand_bits(16));
        data_sel = tlcs_mem_pkg::SRC_SR;
        store_req(a, tlcs_mem_pkg::LEN_LONG, {16'h0000, sr});
        read_at(a);
        c = rand_bits(32);
        src_out = c;
        regs_we = 2'b10;
        @(negedge clk);
        regs_we = 2'b00;
        src_out = rand_bits(32);  // must not be taken
        a = 24'(rand_bits(24));
        data_sel = tlcs_mem_pkg::SRC_EXCPY;
        store_req(a, tlcs_mem_pkg::LEN_WORD, {16'h0000, c[15:0]});
        read_at(a);
        a = 24'(rand_bits(24));
        d = rand_bits(32);
        imm = rand_bits(32);
        sel_imm = 1'b1;
        alu_dout = d;
        data_sel = tlcs_mem_pkg::SRC_ALU;
        store_req(a, tlcs_mem_pkg::LEN_LONG, {d[31:16], imm[15:0]});
        sel_imm = 1'b0;
        read_at(a);

        for (int i = 0; i < N_LD; i++) begin
            operand_load(24'(rand_bits(24)), 24'(rand_bits(24)));
        end

        // mixed traffic with cen gaps
        rand_cen = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            a = 24'(rand_bits(24));
            if (rand_bits(1) != 0) begin
                read_at(a);
                read_at(a + 24'(rand_bits(2)));
            end else begin
                store_alu(a, len_code(rand_bits(2) % 3), rand_bits(32));
                read_at(a);
                read_at(a - 24'd1);
            end
        end
        rand_cen = 1'b0;
        @(negedge clk);
        cen = 1'b1;

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tlcs_memctl.f
rtl/tlcs_mem_pkg.sv
rtl/mem_src_sel.sv
rtl/mem_read_window.sv
rtl/mem_write_split.sv
rtl/mem_ram16.sv
rtl/tlcs_memctl.sv
tb/tb_tlcs_memctl.sv

// File: Bender.yml
package:
  name: tlcs_memctl

sources:
  - rtl/tlcs_mem_pkg.sv
  - rtl/mem_src_sel.sv
  - rtl/mem_read_window.sv
  - rtl/mem_write_split.sv
  - rtl/mem_ram16.sv
  - rtl/tlcs_memctl.sv
  - target: test
    files:
      - tb/tb_tlcs_memctl.sv
